// ==== Makefile ====
SIM := obj_dir/Vtb_mips_core

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): all.f $(wildcard design/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert -j 0 \
		-f all.f --top-module tb_mips_core \
		-Mdir obj_dir -o Vtb_mips_core

clean:
	rm -rf obj_dir

// ==== all.f ====
design/mips_pkg.sv
design/dec_ex_if.sv
design/ex_res_if.sv
design/reg_file.sv
design/instr_decode.sv
design/alu_execute.sv
design/result_stage.sv
design/mips_core_top.sv
dv/tb_mips_core.sv

// ==== design/alu_execute.sv ====
`timescale 1ns/100ps

module alu_execute (
    input  logic       i_clock,
    input  logic       i_rst_n,
    dec_ex_if.execute  dec,
    ex_res_if.execute  res
);
    import mips_pkg::*;

    logic [XLEN-1:0] opnd_a, opnd_b;
    logic [XLEN-1:0] alu_result;

    assign opnd_a = dec.op.opnd_a;
    assign opnd_b = dec.op.opnd_b;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    always_comb begin
        case (dec.op.alu_op)
            ALU_ADD: alu_result = opnd_a + opnd_b;
            ALU_SUB: alu_result = opnd_a - opnd_b;
            ALU_AND: alu_result = opnd_a & opnd_b;
            ALU_OR:  alu_result = opnd_a | opnd_b;
            ALU_XOR: alu_result = opnd_a ^ opnd_b;
            // Signed compare.
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(opnd_a) < $signed(opnd_b)};
            ALU_LUI: alu_result = opnd_b << 16;
            default: alu_result = '0;
        endcase
    end

    // Feeds the instruction now in decode.
    assign dec.fwd_data = alu_result;

    // Execute pipeline register.
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= dec.valid;
        end
    end

    always_ff @(posedge i_clock) begin
        res.we   <= dec.op.we;
        res.dest <= dec.op.dest;
        res.data <= alu_result;
    end

    a_res_valid_known : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        !$isunknown(res.valid)
    );

endmodule

// ==== design/dec_ex_if.sv ====
`timescale 1ns/100ps

interface dec_ex_if;
    import mips_pkg::*;

    // One decoded operation per cycle, no back-pressure.
    logic            valid;
    dec_op_t         op;

    // Combinational ALU result of op, fed back to decode.
    logic [XLEN-1:0] fwd_data;

    modport decode (
        output valid,
        output op,
        input  fwd_data
    );

    modport execute (
        input  valid,
        input  op,
        output fwd_data
    );

endinterface

// ==== design/ex_res_if.sv ====
`timescale 1ns/100ps

interface ex_res_if;
    import mips_pkg::*;

    // Execute result register.
    logic              valid;
    logic              we;
    logic [REG_AW-1:0] dest;
    logic [XLEN-1:0]   data;

    modport execute (output valid, output we, output dest, output data);
    modport result  (input valid, input we, input dest, input data);

    // Decode reads the same entry for forwarding.
    modport fwd     (input valid, input we, input dest, input data);

endinterface

// ==== design/instr_decode.sv ====
`timescale 1ns/100ps

module instr_decode (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic                        i_instr_valid,
    input  logic [mips_pkg::XLEN-1:0]   i_instr,
    input  logic [mips_pkg::XLEN-1:0]   i_pc_plus4,
    output logic                        o_branch_taken,
    output logic [mips_pkg::XLEN-1:0]   o_branch_target,
    dec_ex_if.decode                    dec,
    ex_res_if.fwd                       fwd,
    input  logic                        i_wb_en,
    input  logic [mips_pkg::REG_AW-1:0] i_wb_addr,
    input  logic [mips_pkg::XLEN-1:0]   i_wb_data
);
    import mips_pkg::*;

    opcode_e           opcode;
    funct_e            funct;
    logic [REG_AW-1:0] rs, rt, rd;
    logic [15:0]       imm;
    logic [25:0]       instr_index;
    logic [XLEN-1:0]   rf_data_a, rf_data_b;
    logic [XLEN-1:0]   src_a, src_b;
    logic [XLEN-1:0]   imm_sext, imm_zext;
    alu_op_e           alu_op;
    logic              alu_instr, use_imm, zero_ext, is_beq, is_bne, is_j;
    logic [REG_AW-1:0] dest;
    logic              take_branch;
    logic [XLEN-1:0]   target_next;

    // Field split.
    assign opcode      = opcode_e'(i_instr[31:26]);
    assign funct       = funct_e'(i_instr[5:0]);
    assign rs          = i_instr[25:21];
    assign rt          = i_instr[20:16];
    assign rd          = i_instr[15:11];
    assign imm         = i_instr[15:0];
    assign instr_index = i_instr[25:0];

    reg_file u_reg_file (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_rd_addr_a (rs),
        .i_rd_addr_b (rt),
        .o_rd_data_a (rf_data_a),
        .o_rd_data_b (rf_data_b),
        .i_wr_en     (i_wb_en),
        .i_wr_addr   (i_wb_addr),
        .i_wr_data   (i_wb_data)
    );

    //////////////////////////////////////////////////
    // Operand forwarding
    //////////////////////////////////////////////////

    // Youngest producer wins: execute, then result register, then file.
    function automatic logic [XLEN-1:0] fwd_select(input logic [REG_AW-1:0] src,
                                                   input logic [XLEN-1:0]   rf_val);
        logic [XLEN-1:0] val;
        if (src == '0) begin
            val = '0;
        end else if (dec.valid && dec.op.we && (dec.op.dest == src)) begin
            val = dec.fwd_data;
        end else if (fwd.valid && fwd.we && (fwd.dest == src)) begin
            val = fwd.data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    always_comb begin
        src_a = fwd_select(rs, rf_data_a);
        src_b = fwd_select(rt, rf_data_b);
    end

    //////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////

    always_comb begin
        alu_op    = ALU_ADD;
        alu_instr = 1'b0;
        use_imm   = 1'b1;
        zero_ext  = 1'b0;
        dest      = rt;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                use_imm   = 1'b0;
                dest      = rd;
                alu_instr = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: alu_instr = 1'b0;
                endcase
            end
            OP_ADDIU: alu_instr = 1'b1;
            OP_SLTI: begin
                alu_op    = ALU_SLT;
                alu_instr = 1'b1;
            end
            OP_ANDI: begin
                alu_op    = ALU_AND;
                alu_instr = 1'b1;
                zero_ext  = 1'b1;
            end
            OP_ORI: begin
                alu_op    = ALU_OR;
                alu_instr = 1'b1;
                zero_ext  = 1'b1;
            end
            OP_LUI: begin
                alu_op    = ALU_LUI;
                alu_instr = 1'b1;
                zero_ext  = 1'b1;
            end
            OP_BEQ:  is_beq = 1'b1;
            OP_BNE:  is_bne = 1'b1;
            OP_J:    is_j   = 1'b1;
            default: alu_instr = 1'b0;
        endcase
    end

    assign imm_sext = {{(XLEN-16){imm[15]}}, imm};
    assign imm_zext = {{(XLEN-16){1'b0}}, imm};

    // Branch resolution on forwarded operands.
    assign take_branch = (is_beq && (src_a == src_b)) || (is_bne && (src_a != src_b)) || is_j;
    assign target_next = is_j ? {i_pc_plus4[31:28], instr_index, 2'b00}
                              : i_pc_plus4 + {imm_sext[XLEN-3:0], 2'b00};

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            dec.valid      <= 1'b0;
            o_branch_taken <= 1'b0;
        end else begin
            dec.valid      <= i_instr_valid;
            o_branch_taken <= i_instr_valid && take_branch;
        end
    end

    always_ff @(posedge i_clock) begin
        dec.op.alu_op   <= alu_op;
        dec.op.opnd_a   <= src_a;
        dec.op.opnd_b   <= use_imm ? (zero_ext ? imm_zext : imm_sext) : src_b;
        dec.op.dest     <= dest;
        dec.op.we       <= alu_instr && (dest != '0);
        o_branch_target <= target_next;
    end

    // Fetch presents a known word and PC+4 with every valid.
    a_instr_known : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_instr_valid |-> !$isunknown({i_instr, i_pc_plus4})
    );

endmodule

// ==== design/mips_core_top.sv ====
`timescale 1ns/100ps

module mips_core_top (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic                        i_instr_valid,
    input  logic [mips_pkg::XLEN-1:0]   i_instr,
    input  logic [mips_pkg::XLEN-1:0]   i_pc_plus4,
    output logic                        o_branch_taken,
    output logic [mips_pkg::XLEN-1:0]   o_branch_target,
    output logic                        o_wb_valid,
    output logic [mips_pkg::REG_AW-1:0] o_wb_reg,
    output logic [mips_pkg::XLEN-1:0]   o_wb_data
);
    import mips_pkg::*;

    logic              rf_wr_en;
    logic [REG_AW-1:0] rf_wr_addr;
    logic [XLEN-1:0]   rf_wr_data;

    dec_ex_if u_dec_ex ();
    ex_res_if u_ex_res ();

    //////////////////////////////////////////////////
    // Pipeline stages
    //////////////////////////////////////////////////

    instr_decode u_instr_decode (
        .i_clock         (i_clock),
        .i_rst_n         (i_rst_n),
        .i_instr_valid   (i_instr_valid),
        .i_instr         (i_instr),
        .i_pc_plus4      (i_pc_plus4),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .dec             (u_dec_ex.decode),
        .fwd             (u_ex_res.fwd),
        .i_wb_en         (rf_wr_en),
        .i_wb_addr       (rf_wr_addr),
        .i_wb_data       (rf_wr_data)
    );

    alu_execute u_alu_execute (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .dec     (u_dec_ex.execute),
        .res     (u_ex_res.execute)
    );

    result_stage u_result_stage (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .res          (u_ex_res.result),
        .o_rf_wr_en   (rf_wr_en),
        .o_rf_wr_addr (rf_wr_addr),
        .o_rf_wr_data (rf_wr_data),
        .o_wb_valid   (o_wb_valid),
        .o_wb_reg     (o_wb_reg),
        .o_wb_data    (o_wb_data)
    );

endmodule

// ==== design/mips_pkg.sv ====
package mips_pkg;

    // Data path and register file sizes.
    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    //////////////////////////////////////////////////
    // Instruction encodings
    //////////////////////////////////////////////////

    // Primary opcode, bits 31:26.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_e;

    // Function code of SPECIAL, bits 5:0.
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_LUI = 3'd6
    } alu_op_e;

    //////////////////////////////////////////////////
    // Decode to execute payload
    //////////////////////////////////////////////////

    // Operands arrive forwarded, immediate already in opnd_b.
    typedef struct packed {
        alu_op_e             alu_op;
        logic [XLEN-1:0]     opnd_a;
        logic [XLEN-1:0]     opnd_b;
        logic [REG_AW-1:0]   dest;
        logic                we;
    } dec_op_t;

endpackage

// ==== design/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic [mips_pkg::REG_AW-1:0] i_rd_addr_a,
    input  logic [mips_pkg::REG_AW-1:0] i_rd_addr_b,
    output logic [mips_pkg::XLEN-1:0]   o_rd_data_a,
    output logic [mips_pkg::XLEN-1:0]   o_rd_data_b,
    input  logic                        i_wr_en,
    input  logic [mips_pkg::REG_AW-1:0] i_wr_addr,
    input  logic [mips_pkg::XLEN-1:0]   i_wr_data
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Register 0 is hardwired to zero.
    assign o_rd_data_a = (i_rd_addr_a == '0) ? '0 : regs[i_rd_addr_a];
    assign o_rd_data_b = (i_rd_addr_b == '0) ? '0 : regs[i_rd_addr_b];

    // The result stage must filter out r0 writes upstream.
    a_no_wr_r0 : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_wr_en |-> (i_wr_addr != '0)
    );

endmodule

// ==== design/result_stage.sv ====
`timescale 1ns/100ps

module result_stage (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    ex_res_if.result                    res,
    output logic                        o_rf_wr_en,
    output logic [mips_pkg::REG_AW-1:0] o_rf_wr_addr,
    output logic [mips_pkg::XLEN-1:0]   o_rf_wr_data,
    output logic                        o_wb_valid,
    output logic [mips_pkg::REG_AW-1:0] o_wb_reg,
    output logic [mips_pkg::XLEN-1:0]   o_wb_data
);

    // Register file write, same edge as the write-back register.
    assign o_rf_wr_en   = res.valid && res.we && (res.dest != '0);
    assign o_rf_wr_addr = res.dest;
    assign o_rf_wr_data = res.data;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= o_rf_wr_en;
        end
    end

    always_ff @(posedge i_clock) begin
        o_wb_reg  <= res.dest;
        o_wb_data <= res.data;
    end

    // A writing entry from execute carries a known address and value.
    a_res_entry_known : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        (res.valid && res.we) |-> !$isunknown({res.dest, res.data})
    );

endmodule

// ==== dv/tb_mips_core.sv ====
`timescale 1ns/100ps

module tb_mips_core;
    import mips_pkg::*;

    localparam int N_RANDOM        = 200;
    localparam int DIRECTED_SLOTS  = 16 + 64;
    localparam int WATCHDOG_CYCLES = DIRECTED_SLOTS + 2 * N_RANDOM + 40;

    typedef struct packed {
        logic [REG_AW-1:0] dest;
        logic [XLEN-1:0]   data;
    } wb_entry_t;

    logic              i_clock = 1'b0;
    logic              i_rst_n;
    logic              i_instr_valid;
    logic [XLEN-1:0]   i_instr;
    logic [XLEN-1:0]   i_pc_plus4;
    logic              o_branch_taken;
    logic [XLEN-1:0]   o_branch_target;
    logic              o_wb_valid;
    logic [REG_AW-1:0] o_wb_reg;
    logic [XLEN-1:0]   o_wb_data;

    // Reference state.
    logic [XLEN-1:0] model_regs [NUM_REGS];
    logic [XLEN-1:0] pc4;
    integer          seed;
    wb_entry_t       exp_wb_q [$];

    // Expected outcome of the slot driven last, then aligned to DUT timing.
    logic            cur_br_taken  = 1'b0;
    logic [XLEN-1:0] cur_br_target = '0;
    logic            cur_wb        = 1'b0;
    logic            exp_br_taken  = 1'b0;
    logic [XLEN-1:0] exp_br_target = '0;
    logic [2:0]      wb_slot       = '0;

    mips_core_top DUT (
        .i_clock         (i_clock),
        .i_rst_n         (i_rst_n),
        .i_instr_valid   (i_instr_valid),
        .i_instr         (i_instr),
        .i_pc_plus4      (i_pc_plus4),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_wb_valid      (o_wb_valid),
        .o_wb_reg        (o_wb_reg),
        .o_wb_data       (o_wb_data)
    );

    always #50 i_clock = ~i_clock;

    //////////////////////////////////////////////////
    // Reporting and compare tasks
    //////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_wb(input logic got_valid, input logic exp_valid,
                            input logic [REG_AW-1:0] got_reg, input logic [REG_AW-1:0] exp_reg,
                            input logic [XLEN-1:0] got_data, input logic [XLEN-1:0] exp_data);
        if (got_valid !== exp_valid) begin
            $display("** Error o_wb_valid: got %h expected %h", got_valid, exp_valid);
            abort_run("write-back valid mismatch");
        end else if (exp_valid && (got_reg !== exp_reg)) begin
            $display("** Error o_wb_reg: got %h expected %h", got_reg, exp_reg);
            abort_run("write-back register mismatch");
        end else if (exp_valid && (got_data !== exp_data)) begin
            $display("** Error o_wb_data: got %h expected %h", got_data, exp_data);
            abort_run("write-back data mismatch");
        end
    endtask

    task automatic check_branch(input logic got_taken, input logic exp_taken,
                                input logic [XLEN-1:0] got_target,
                                input logic [XLEN-1:0] exp_target);
        if (got_taken !== exp_taken) begin
            $display("** Error o_branch_taken: got %h expected %h", got_taken, exp_taken);
            abort_run("branch taken mismatch");
        end else if (exp_taken && (got_target !== exp_target)) begin
            $display("** Error o_branch_target: got %h expected %h", got_target, exp_target);
            abort_run("branch target mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model and encoders
    //////////////////////////////////////////////////

    function automatic logic [31:0] rtype_word(input funct_e fn, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(input opcode_e op, input logic [4:0] rt,
                                               input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(input logic [25:0] index);
        return {OP_J, index};
    endfunction

    // Program-order execution; the pipeline forwards everything.
    task automatic model_step(input logic [31:0] instr, input logic [31:0] pc_next,
                              output logic wb_en, output logic [4:0] wb_reg,
                              output logic [31:0] wb_data, output logic br_taken,
                              output logic [31:0] br_target);
        opcode_e     op;
        funct_e      fn;
        logic [31:0] a, b, sx, zx;
        op = opcode_e'(instr[31:26]);
        fn = funct_e'(instr[5:0]);
        a  = model_regs[instr[25:21]];
        b  = model_regs[instr[20:16]];
        sx = {{16{instr[15]}}, instr[15:0]};
        zx = {16'h0000, instr[15:0]};
        wb_en     = 1'b1;
        wb_reg    = instr[20:16];
        wb_data   = '0;
        br_taken  = 1'b0;
        br_target = '0;
        case (op)
            OP_SPECIAL: begin
                wb_reg = instr[15:11];
                case (fn)
                    FN_ADDU: wb_data = a + b;
                    FN_SUBU: wb_data = a - b;
                    FN_AND:  wb_data = a & b;
                    FN_OR:   wb_data = a | b;
                    FN_XOR:  wb_data = a ^ b;
                    FN_SLT:  wb_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wb_en = 1'b0;
                endcase
            end
            OP_ADDIU: wb_data = a + sx;
            OP_SLTI:  wb_data = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            OP_ANDI:  wb_data = a & zx;
            OP_ORI:   wb_data = a | zx;
            OP_LUI:   wb_data = {instr[15:0], 16'h0000};
            OP_BEQ, OP_BNE: begin
                wb_en     = 1'b0;
                br_taken  = (op == OP_BEQ) ? (a == b) : (a != b);
                br_target = pc_next + (sx << 2);
            end
            OP_J: begin
                wb_en     = 1'b0;
                br_taken  = 1'b1;
                br_target = {pc_next[31:28], instr[25:0], 2'b00};
            end
            default: wb_en = 1'b0;
        endcase
        if (wb_reg == 5'd0) begin
            wb_en = 1'b0;
        end
        if (wb_en) begin
            model_regs[wb_reg] = wb_data;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus and monitor
    //////////////////////////////////////////////////

    task automatic issue(input logic [31:0] instr);
        logic        wb_en, br_taken;
        logic [4:0]  wb_reg;
        logic [31:0] wb_data, br_target;
        wb_entry_t   entry;
        model_step(instr, pc4, wb_en, wb_reg, wb_data, br_taken, br_target);
        @(posedge i_clock);
        i_instr_valid <= 1'b1;
        i_instr       <= instr;
        i_pc_plus4    <= pc4;
        cur_br_taken  <= br_taken;
        cur_br_target <= br_target;
        cur_wb        <= wb_en;
        if (wb_en) begin
            entry.dest = wb_reg;
            entry.data = wb_data;
            exp_wb_q.push_back(entry);
        end
        // The fetch unit follows a taken branch.
        pc4 = br_taken ? br_target + 32'd4 : pc4 + 32'd4;
    endtask

    task automatic idle_cycle();
        @(posedge i_clock);
        i_instr_valid <= 1'b0;
        cur_br_taken  <= 1'b0;
        cur_wb        <= 1'b0;
    endtask

    // Branch outputs one edge after sampling, write-back two edges later.
    always @(posedge i_clock) begin
        exp_br_taken  <= cur_br_taken;
        exp_br_target <= cur_br_target;
        wb_slot       <= {wb_slot[1:0], cur_wb};
    end

    always @(negedge i_clock) begin : output_monitor
        wb_entry_t entry;
        check_branch(o_branch_taken, exp_br_taken, o_branch_target, exp_br_target);
        if ((o_wb_valid === 1'b1) && (exp_wb_q.size() == 0)) begin
            abort_run("o_wb_valid high with no write-back expected");
        end else if (o_wb_valid === 1'b1) begin
            entry = exp_wb_q.pop_front();
            check_wb(o_wb_valid, wb_slot[2], o_wb_reg, entry.dest, o_wb_data, entry.data);
        end else begin
            check_wb(o_wb_valid, wb_slot[2], '0, '0, '0, '0);
        end
    end

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic reset_check();
        @(negedge i_clock);
        check_wb(o_wb_valid, 1'b0, '0, '0, '0, '0);
        check_branch(o_branch_taken, 1'b0, '0, '0);
        issue(rtype_word(FN_ADDU, 5'd1, 5'd0, 5'd0));
    endtask

    task automatic rtype_chain();
        issue(itype_word(OP_ADDIU, 5'd1, 5'd0, 16'h1234));
        issue(itype_word(OP_ADDIU, 5'd2, 5'd0, 16'hfffb));
        issue(rtype_word(FN_ADDU, 5'd3, 5'd1, 5'd2));
        issue(rtype_word(FN_SUBU, 5'd4, 5'd3, 5'd1));
        issue(rtype_word(FN_AND, 5'd5, 5'd4, 5'd3));
        issue(rtype_word(FN_OR, 5'd6, 5'd5, 5'd2));
        issue(rtype_word(FN_XOR, 5'd7, 5'd6, 5'd5));
        issue(rtype_word(FN_SLT, 5'd8, 5'd2, 5'd1));
        issue(rtype_word(FN_SLT, 5'd9, 5'd1, 5'd2));
        idle_cycle();
        issue(rtype_word(FN_ADDU, 5'd10, 5'd7, 5'd8));
    endtask

    task automatic imm_extension();
        issue(itype_word(OP_ADDIU, 5'd11, 5'd0, 16'h8000));
        issue(itype_word(OP_SLTI, 5'd12, 5'd11, 16'hffff));
        issue(itype_word(OP_SLTI, 5'd13, 5'd1, 16'hfff0));
        issue(itype_word(OP_ANDI, 5'd14, 5'd11, 16'hffff));
        issue(itype_word(OP_ORI, 5'd15, 5'd0, 16'h8001));
        issue(itype_word(OP_LUI, 5'd16, 5'd0, 16'hbeef));
        issue(itype_word(OP_ORI, 5'd16, 5'd16, 16'h1234));
    endtask

    task automatic zero_register();
        issue(itype_word(OP_ADDIU, 5'd0, 5'd0, 16'h0005));
        issue(rtype_word(FN_ADDU, 5'd0, 5'd1, 5'd2));
        issue(rtype_word(FN_ADDU, 5'd17, 5'd0, 5'd0));
        issue(itype_word(OP_ORI, 5'd18, 5'd0, 16'h0007));
    endtask

    task automatic branch_cases();
        pc4 = 32'h8000_1000;
        issue(itype_word(OP_ADDIU, 5'd19, 5'd0, 16'h0003));
        issue(itype_word(OP_BEQ, 5'd19, 5'd19, 16'h0004));
        issue(itype_word(OP_BNE, 5'd0, 5'd19, 16'hfffe));
        issue(itype_word(OP_BEQ, 5'd0, 5'd19, 16'h0010));
        issue(itype_word(OP_ADDIU, 5'd20, 5'd0, 16'h0003));
        issue(itype_word(OP_BEQ, 5'd19, 5'd20, 16'h0020));
        issue(itype_word(OP_BNE, 5'd19, 5'd20, 16'h0020));
        issue(jump_word(26'h3ff_ffff));
        issue(jump_word(26'h001_2345));
    endtask

    task automatic random_instr(output logic [31:0] instr);
        logic [31:0] r, r2;
        logic [4:0]  rs, rt, rd;
        int          kind;
        r    = $random(seed);
        r2   = $random(seed);
        kind = int'(r[3:0]) % 14;
        // Registers 0 to 7 only, for dense dependencies.
        rs   = {2'b00, r[6:4]};
        rt   = {2'b00, r[9:7]};
        rd   = {2'b00, r[12:10]};
        case (kind)
            0:       instr = rtype_word(FN_ADDU, rd, rs, rt);
            1:       instr = rtype_word(FN_SUBU, rd, rs, rt);
            2:       instr = rtype_word(FN_AND, rd, rs, rt);
            3:       instr = rtype_word(FN_OR, rd, rs, rt);
            4:       instr = rtype_word(FN_XOR, rd, rs, rt);
            5:       instr = rtype_word(FN_SLT, rd, rs, rt);
            6:       instr = itype_word(OP_ADDIU, rt, rs, r2[15:0]);
            7:       instr = itype_word(OP_SLTI, rt, rs, r2[15:0]);
            8:       instr = itype_word(OP_ANDI, rt, rs, r2[15:0]);
            9:       instr = itype_word(OP_ORI, rt, rs, r2[15:0]);
            10:      instr = itype_word(OP_LUI, rt, rs, r2[15:0]);
            11:      instr = itype_word(OP_BEQ, rt, rs, r2[15:0]);
            12:      instr = itype_word(OP_BNE, rt, rs, r2[15:0]);
            default: instr = jump_word(r2[25:0]);
        endcase
    endtask

    task automatic random_stream();
        logic [31:0] gap, instr;
        for (int n = 0; n < N_RANDOM; n++) begin
            gap = $random(seed);
            if (gap[1:0] == 2'b00) begin
                idle_cycle();
            end
            random_instr(instr);
            issue(instr);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 100);
        abort_run("watchdog expired before the tests completed");
    end

    initial begin
        seed          = 32'h9bd3_d11f;
        pc4           = 32'h0040_0004;
        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_pc_plus4    = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge i_clock);
        i_rst_n <= 1'b1;
        reset_check();
        rtype_chain();
        imm_extension();
        zero_register();
        branch_cases();
        random_stream();
        idle_cycle();
        // Drain the three pipeline stages.
        repeat (4) @(posedge i_clock);
        @(negedge i_clock);
        if (exp_wb_q.size() != 0) begin
            abort_run("expected write-backs never appeared");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
